//--- src/capture_pkg.sv
`default_nettype none

package capture_pkg;

    typedef logic [23:0] pixel_t;
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  csr_addr_t;
    typedef logic [31:0] count_t;
    typedef logic [9:0]  level_t;

    // burst geometry, one word per beat
    localparam int BURST_LEN   = 16;
    localparam int BURST_BYTES = BURST_LEN * 4;
    localparam int BEAT_W      = $clog2(BURST_LEN);
    localparam logic [BEAT_W-1:0] BEAT_LAST = BEAT_W'(BURST_LEN - 1);
    localparam logic [7:0] AWLEN = 8'(BURST_LEN - 1);

    localparam int FIFO_DEPTH = 512;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);

    // register map, byte offsets
    localparam csr_addr_t REG_START_ADDR  = 8'h00;
    localparam csr_addr_t REG_CTRL        = 8'h04;
    localparam csr_addr_t REG_LINE_PIXELS = 8'h08;
    localparam csr_addr_t REG_FRAME_LINES = 8'h0C;
    localparam csr_addr_t REG_FRAME_COUNT = 8'h10;
    localparam csr_addr_t REG_STATUS      = 8'h14;

    localparam int CTRL_ENABLE     = 0;
    localparam int STAT_FRAME_DONE = 0;
    localparam int STAT_OVERFLOW   = 1;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } burst_state_t;

endpackage

`default_nettype wire

//--- src/fifo_rd_if.sv
`default_nettype none

// read side of the word FIFO, pop only while not empty
interface fifo_rd_if;
    capture_pkg::word_t  data;
    logic                empty;
    capture_pkg::level_t level;
    logic                pop;

    modport fifo (
        output data,
        output empty,
        output level,
        input  pop
    );

    modport burst (
        input  data,
        input  empty,
        input  level,
        output pop
    );
endinterface

`default_nettype wire

//--- src/video_stats_if.sv
`default_nettype none

interface video_stats_if;
    capture_pkg::count_t line_pixels;
    capture_pkg::count_t frame_lines;
    capture_pkg::count_t frame_count;
    // one cycle pulse on vsync falling edge
    logic                frame_end;

    modport source (
        output line_pixels,
        output frame_lines,
        output frame_count,
        output frame_end
    );

    modport sink (
        input line_pixels,
        input frame_lines,
        input frame_count,
        input frame_end
    );
endinterface

`default_nettype wire

//--- src/pixel_repacker.sv
`default_nettype none

module pixel_repacker (
    input  wire                      clk_sys,
    input  wire                      rst_sys_n,
    input  wire capture_pkg::pixel_t video_data,
    input  wire                      video_de,
    output capture_pkg::word_t       word,
    output logic                     word_valid
);
    // bytes waiting in hold, counts 0, 3, 2, 1 over four pixels
    logic [1:0]          phase;
    capture_pkg::pixel_t hold;

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            phase      <= 2'd0;
            word_valid <= 1'b0;
        end else if (!video_de) begin
            // partial word at end of line is dropped
            phase      <= 2'd0;
            word_valid <= 1'b0;
        end else begin
            phase      <= phase - 2'd1;
            word_valid <= (phase != 2'd0);
        end
    end

    // first byte of the stream lands in bits 7:0
    always_ff @(posedge clk_sys) begin
        if (video_de) begin
            case (phase)
                2'd0: begin
                    hold <= video_data;
                end
                2'd3: begin
                    word <= {video_data[7:0], hold[23:0]};
                    hold <= {8'h00, video_data[23:8]};
                end
                2'd2: begin
                    word <= {video_data[15:0], hold[15:0]};
                    hold <= {16'h0000, video_data[23:16]};
                end
                default: begin
                    word <= {video_data, hold[7:0]};
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/pixel_fifo.sv
`default_nettype none

module pixel_fifo (
    input  wire                     clk_sys,
    input  wire                     rst_sys_n,
    input  wire capture_pkg::word_t word,
    input  wire                     word_valid,
    fifo_rd_if.fifo                 rd,
    output logic                    overflow
);
    capture_pkg::word_t            mem [capture_pkg::FIFO_DEPTH];
    logic [capture_pkg::PTR_W-1:0] wr_ptr;
    logic [capture_pkg::PTR_W-1:0] rd_ptr;
    capture_pkg::level_t           level;
    logic                          full;
    logic                          push;

    assign full     = (level == capture_pkg::level_t'(capture_pkg::FIFO_DEPTH));
    assign push     = word_valid && !full;
    // show-ahead read, head word is valid whenever not empty
    assign rd.data  = mem[rd_ptr];
    assign rd.empty = (level == '0);
    assign rd.level = level;

    always_ff @(posedge clk_sys) begin
        if (push) begin
            mem[wr_ptr] <= word;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            level    <= level + capture_pkg::level_t'(push) - capture_pkg::level_t'(rd.pop);
            // word arrived while full and was lost
            overflow <= word_valid && full;
        end
    end

    a_no_pop_empty: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        rd.pop |-> !rd.empty)
        else $error("pop while FIFO empty");

endmodule

`default_nettype wire

//--- src/video_stats.sv
`default_nettype none

module video_stats (
    input  wire           clk_sys,
    input  wire           rst_sys_n,
    input  wire           video_de,
    input  wire           video_hs,
    input  wire           video_vs,
    video_stats_if.source stats,
    output logic          frame_start
);
    logic                hs_q;
    logic                vs_q;
    logic                hs_rise;
    logic                vs_rise;
    logic                vs_fall;
    capture_pkg::count_t pix_cnt;
    capture_pkg::count_t line_cnt;

    assign hs_rise = video_hs && !hs_q;
    assign vs_rise = video_vs && !vs_q;
    assign vs_fall = !video_vs && vs_q;

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            hs_q              <= 1'b0;
            vs_q              <= 1'b0;
            frame_start       <= 1'b0;
            stats.frame_end   <= 1'b0;
            pix_cnt           <= '0;
            line_cnt          <= '0;
            stats.line_pixels <= '0;
            stats.frame_lines <= '0;
            stats.frame_count <= '0;
        end else begin
            hs_q            <= video_hs;
            vs_q            <= video_vs;
            frame_start     <= vs_rise;
            stats.frame_end <= vs_fall;

            // active pixels of the line just finished
            if (hs_rise) begin
                stats.line_pixels <= pix_cnt;
                pix_cnt           <= '0;
            end else if (video_de) begin
                pix_cnt <= pix_cnt + 1'b1;
            end

            // lines of the previous frame
            if (vs_rise) begin
                stats.frame_lines <= line_cnt;
                stats.frame_count <= stats.frame_count + 1'b1;
                line_cnt          <= '0;
            end else if (hs_rise) begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/csr_regs.sv
`default_nettype none

module csr_regs (
    input  wire                         clk_sys,
    input  wire                         rst_sys_n,
    input  wire capture_pkg::csr_addr_t csr_addr,
    input  wire                         csr_read,
    input  wire                         csr_write,
    input  wire capture_pkg::word_t     csr_wdata,
    output capture_pkg::word_t          csr_rdata,
    output logic                        csr_rvalid,
    video_stats_if.sink                 stats,
    input  wire                         overflow,
    output capture_pkg::addr_t          start_addr,
    output logic                        dma_enable,
    output logic                        addr_reload
);
    logic               frame_done;
    logic               ovf_seen;
    logic               wr_base;
    logic               status_rd;
    capture_pkg::word_t rd_mux;

    assign wr_base   = csr_write && (csr_addr == capture_pkg::REG_START_ADDR);
    assign status_rd = csr_read && (csr_addr == capture_pkg::REG_STATUS);

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            start_addr  <= '0;
            dma_enable  <= 1'b0;
            addr_reload <= 1'b0;
        end else begin
            // new base is pushed to the address pointer next cycle
            addr_reload <= wr_base;
            if (wr_base) begin
                start_addr <= csr_wdata;
            end
            if (csr_write && (csr_addr == capture_pkg::REG_CTRL)) begin
                dma_enable <= csr_wdata[capture_pkg::CTRL_ENABLE];
            end
        end
    end

    // sticky flags, set takes priority over the clearing read
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            frame_done <= 1'b0;
            ovf_seen   <= 1'b0;
        end else begin
            if (stats.frame_end) begin
                frame_done <= 1'b1;
            end else if (status_rd) begin
                frame_done <= 1'b0;
            end
            if (overflow) begin
                ovf_seen <= 1'b1;
            end else if (status_rd) begin
                ovf_seen <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        case (csr_addr)
            capture_pkg::REG_START_ADDR:  rd_mux = start_addr;
            capture_pkg::REG_CTRL:        rd_mux[capture_pkg::CTRL_ENABLE] = dma_enable;
            capture_pkg::REG_LINE_PIXELS: rd_mux = stats.line_pixels;
            capture_pkg::REG_FRAME_LINES: rd_mux = stats.frame_lines;
            capture_pkg::REG_FRAME_COUNT: rd_mux = stats.frame_count;
            capture_pkg::REG_STATUS: begin
                rd_mux[capture_pkg::STAT_FRAME_DONE] = frame_done;
                rd_mux[capture_pkg::STAT_OVERFLOW]   = ovf_seen;
            end
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            csr_rvalid <= 1'b0;
        end else begin
            csr_rvalid <= csr_read;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (csr_read) begin
            csr_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

//--- src/burst_ctrl.sv
`default_nettype none

module burst_ctrl (
    input  wire                     clk_sys,
    input  wire                     rst_sys_n,
    fifo_rd_if.burst                rd,
    input  wire capture_pkg::addr_t start_addr,
    input  wire                     dma_enable,
    input  wire                     addr_reload,
    input  wire                     frame_start,
    output capture_pkg::addr_t      awaddr,
    output logic [7:0]              awlen,
    output logic                    awvalid,
    input  wire                     awready,
    output capture_pkg::word_t      wdata,
    output logic                    wlast,
    output logic                    wvalid,
    input  wire                     wready,
    input  wire                     bvalid
);
    capture_pkg::burst_state_t      state;
    logic [capture_pkg::BEAT_W-1:0] beat_cnt;
    capture_pkg::addr_t             next_addr;
    logic                           last_beat;
    logic                           burst_ready;

    assign last_beat   = (beat_cnt == capture_pkg::BEAT_LAST);
    assign burst_ready = dma_enable
                         && (rd.level >= capture_pkg::level_t'(capture_pkg::BURST_LEN));

    assign awvalid = (state == capture_pkg::ADDR);
    assign awaddr  = next_addr;
    assign awlen   = capture_pkg::AWLEN;
    // a full burst is already in the FIFO, so DATA never sees it empty
    assign wvalid  = (state == capture_pkg::DATA);
    assign wlast   = wvalid && last_beat;
    assign wdata   = rd.data;
    assign rd.pop  = wvalid && wready;

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            state    <= capture_pkg::IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                capture_pkg::IDLE: begin
                    if (burst_ready) begin
                        state <= capture_pkg::ADDR;
                    end
                end
                capture_pkg::ADDR: begin
                    if (awready) begin
                        state    <= capture_pkg::DATA;
                        beat_cnt <= '0;
                    end
                end
                capture_pkg::DATA: begin
                    if (wready) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state <= capture_pkg::RESP;
                        end
                    end
                end
                capture_pkg::RESP: begin
                    if (bvalid) begin
                        state <= capture_pkg::IDLE;
                    end
                end
                default: state <= capture_pkg::IDLE;
            endcase
        end
    end

    // back to base on a new frame or a new base address
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            next_addr <= '0;
        end else if (addr_reload || frame_start) begin
            next_addr <= start_addr;
        end else if (awvalid && awready) begin
            next_addr <= next_addr + capture_pkg::addr_t'(capture_pkg::BURST_BYTES);
        end
    end

    a_aw_hold: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("AW request changed before awready");

    a_w_hold: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else $error("W beat changed before wready");

    a_data_avail: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        wvalid |-> !rd.empty)
        else $error("wvalid while FIFO empty");

endmodule

`default_nettype wire

//--- src/capture_top.sv
`default_nettype none

module capture_top (
    input  wire                         clk_sys,
    input  wire                         rst_sys_n,
    input  wire capture_pkg::pixel_t    video_data,
    input  wire                         video_de,
    input  wire                         video_hs,
    input  wire                         video_vs,
    input  wire capture_pkg::csr_addr_t csr_addr,
    input  wire                         csr_read,
    input  wire                         csr_write,
    input  wire capture_pkg::word_t     csr_wdata,
    output wire capture_pkg::word_t     csr_rdata,
    output wire                         csr_rvalid,
    output wire capture_pkg::addr_t     awaddr,
    output wire [7:0]                   awlen,
    output wire                         awvalid,
    input  wire                         awready,
    output wire capture_pkg::word_t     wdata,
    output wire                         wlast,
    output wire                         wvalid,
    input  wire                         wready,
    input  wire                         bvalid
);
    wire capture_pkg::word_t packed_word;
    wire                     packed_valid;
    wire                     overflow;
    wire capture_pkg::addr_t start_addr;
    wire                     dma_enable;
    wire                     addr_reload;
    wire                     frame_start;

    fifo_rd_if     fifo_rd ();
    video_stats_if stats ();

    pixel_repacker u_repacker (
        .clk_sys    (clk_sys),
        .rst_sys_n  (rst_sys_n),
        .video_data (video_data),
        .video_de   (video_de),
        .word       (packed_word),
        .word_valid (packed_valid)
    );

    pixel_fifo u_fifo (
        .clk_sys    (clk_sys),
        .rst_sys_n  (rst_sys_n),
        .word       (packed_word),
        .word_valid (packed_valid),
        .rd         (fifo_rd.fifo),
        .overflow   (overflow)
    );

    video_stats u_stats (
        .clk_sys     (clk_sys),
        .rst_sys_n   (rst_sys_n),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs),
        .stats       (stats.source),
        .frame_start (frame_start)
    );

    csr_regs u_csr (
        .clk_sys     (clk_sys),
        .rst_sys_n   (rst_sys_n),
        .csr_addr    (csr_addr),
        .csr_read    (csr_read),
        .csr_write   (csr_write),
        .csr_wdata   (csr_wdata),
        .csr_rdata   (csr_rdata),
        .csr_rvalid  (csr_rvalid),
        .stats       (stats.sink),
        .overflow    (overflow),
        .start_addr  (start_addr),
        .dma_enable  (dma_enable),
        .addr_reload (addr_reload)
    );

    burst_ctrl u_burst (
        .clk_sys     (clk_sys),
        .rst_sys_n   (rst_sys_n),
        .rd          (fifo_rd.burst),
        .start_addr  (start_addr),
        .dma_enable  (dma_enable),
        .addr_reload (addr_reload),
        .frame_start (frame_start),
        .awaddr      (awaddr),
        .awlen       (awlen),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wlast       (wlast),
        .wvalid      (wvalid),
        .wready      (wready),
        .bvalid      (bvalid)
    );

endmodule

`default_nettype wire

//--- verification/tb_capture.sv
`default_nettype none

module tb_capture;
    localparam int SEED      = 22;
    localparam int LINE_PIX  = 32;
    localparam int BLANK     = 6;
    localparam int HS_LEN    = 2;
    localparam int NUM_LINES = 8;
    localparam int BIG_LINES = 24;
    localparam int LINE_CYC  = LINE_PIX + 1 + BLANK + HS_LEN;
    localparam int TIMEOUT   = (2 * NUM_LINES + BIG_LINES) * LINE_CYC * 4 + 2000;
    localparam logic [31:0] BASE0 = 32'h0010_0000;
    localparam logic [31:0] BASE1 = 32'h0020_0400;

    logic clk_sys = 1'b0;
    logic rst_sys_n;
    logic [23:0] video_data;
    logic video_de;
    logic video_hs;
    logic video_vs;
    capture_pkg::csr_addr_t csr_addr;
    logic csr_read;
    logic csr_write;
    capture_pkg::word_t csr_wdata;
    capture_pkg::word_t csr_rdata;
    capture_pkg::word_t wdata;
    logic csr_rvalid;
    logic awvalid;
    logic wlast;
    logic wvalid;
    capture_pkg::addr_t awaddr;
    logic [7:0] awlen;
    logic awready = 1'b0;
    logic wready = 1'b0;
    logic bvalid = 1'b0;

    integer seed = SEED;
    integer stall_seed = SEED;
    int errors = 0;
    int words_checked = 0;
    int aw_count = 0;
    int burst_idx = 0;
    int beat = 0;
    int vs_count = 0;
    logic resp_pending = 1'b0;
    capture_pkg::addr_t base = '0;
    capture_pkg::addr_t waddr = '0;
    logic [7:0] byte_q[$];
    capture_pkg::word_t exp_q[$];
    capture_pkg::word_t frame_q[$];
    capture_pkg::word_t mem[capture_pkg::addr_t];

    always #5 clk_sys = ~clk_sys;

    capture_top UUT (.*);

    task check_value(input logic [31:0] actual, input logic [31:0] expected, input string what);
        assert (actual === expected) else begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // memory slave with random stalls and one response per burst
    always @(posedge clk_sys) begin
        logic [31:0] r;
        r = $random(stall_seed);
        awready <= r[0];
        wready  <= r[1] | r[2];
        bvalid  <= resp_pending && r[3];
    end

    // handshakes are sampled half a cycle before the DUT takes them
    always @(negedge clk_sys) begin
        if (rst_sys_n) begin
            if (awvalid && awready) begin
                check_value(awaddr, base + burst_idx * capture_pkg::BURST_LEN * 4, "awaddr");
                check_value(awlen, capture_pkg::BURST_LEN - 1, "awlen");
                burst_idx++;
                aw_count++;
                waddr = awaddr;
            end
            if (wvalid && wready) begin
                mem[waddr] = wdata;
                waddr += 4;
                check_value(wlast, beat == capture_pkg::BURST_LEN - 1, "wlast");
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("W beat at time %0t arrived when no word was expected", $time);
                end
                if (exp_q.size() != 0) begin
                    check_value(wdata, exp_q.pop_front(), "wdata");
                end
                words_checked++;
                beat = (beat == capture_pkg::BURST_LEN - 1) ? 0 : beat + 1;
                if (wlast) begin
                    resp_pending = 1'b1;
                end
            end
            if (bvalid) begin
                resp_pending = 1'b0;
            end
        end
    end

    task write_reg(input capture_pkg::csr_addr_t addr, input capture_pkg::word_t data);
        @(posedge clk_sys);
        csr_addr  <= addr;
        csr_wdata <= data;
        csr_write <= 1'b1;
        @(posedge clk_sys);
        csr_write <= 1'b0;
    endtask

    task read_reg(input capture_pkg::csr_addr_t addr, output capture_pkg::word_t data);
        @(posedge clk_sys);
        csr_addr <= addr;
        csr_read <= 1'b1;
        @(negedge clk_sys);
        check_value(csr_rvalid, 0, "csr_rvalid early");
        @(posedge clk_sys);
        csr_read <= 1'b0;
        @(negedge clk_sys);
        check_value(csr_rvalid, 1, "csr_rvalid");
        data = csr_rdata;
    endtask

    // each pixel adds three bytes low byte first and every four bytes make a word
    task model_pixel(input logic [23:0] pix);
        capture_pkg::word_t w;
        byte_q.push_back(pix[7:0]);
        byte_q.push_back(pix[15:8]);
        byte_q.push_back(pix[23:16]);
        if (byte_q.size() >= 4) begin
            for (int i = 0; i < 4; i++) begin
                w[8*i +: 8] = byte_q.pop_front();
            end
            // a full FIFO keeps its oldest words and drops new ones
            if (exp_q.size() < capture_pkg::FIFO_DEPTH) begin
                exp_q.push_back(w);
                frame_q.push_back(w);
            end
        end
    endtask

    task send_lines(input int nlines);
        logic [31:0] rnd;
        for (int l = 0; l < nlines; l++) begin
            for (int p = 0; p < LINE_PIX; p++) begin
                rnd = $random(seed);
                @(posedge clk_sys);
                video_de   <= 1'b1;
                video_data <= rnd[23:0];
                model_pixel(rnd[23:0]);
            end
            @(posedge clk_sys);
            video_de <= 1'b0;
            byte_q.delete();
            repeat (BLANK) @(posedge clk_sys);
            video_hs <= 1'b1;
            repeat (HS_LEN) @(posedge clk_sys);
            video_hs <= 1'b0;
        end
    endtask

    task wait_drain;
        while (exp_q.size() != 0 || resp_pending) @(posedge clk_sys);
        repeat (2) @(posedge clk_sys);
    endtask

    task vsync_pulse;
        logic [31:0] gap;
        gap = $random(seed);
        repeat (gap[3:0]) @(posedge clk_sys);
        @(posedge clk_sys);
        video_vs <= 1'b1;
        repeat (2) @(posedge clk_sys);
        video_vs <= 1'b0;
        vs_count++;
        burst_idx = 0;
        repeat (3) @(posedge clk_sys);
    endtask

    task check_stats(input int nlines, input logic ovf);
        capture_pkg::word_t d;
        read_reg(capture_pkg::REG_LINE_PIXELS, d);
        check_value(d, LINE_PIX, "line_pixels");
        read_reg(capture_pkg::REG_FRAME_LINES, d);
        check_value(d, nlines, "frame_lines");
        read_reg(capture_pkg::REG_FRAME_COUNT, d);
        check_value(d, vs_count, "frame_count");
        read_reg(capture_pkg::REG_STATUS, d);
        check_value(d[1:0], {ovf, 1'b1}, "status");
        read_reg(capture_pkg::REG_STATUS, d);
        check_value(d[1:0], 2'b00, "status after clear");
    endtask

    task check_memory;
        for (int i = 0; i < frame_q.size(); i++) begin
            check_value(mem[base + 4 * i], frame_q[i], "memory");
        end
    endtask

    task run_frame(input int nlines);
        frame_q.delete();
        send_lines(nlines);
        wait_drain();
        vsync_pulse();
        check_stats(nlines, 1'b0);
        check_memory();
    endtask

    initial begin
        repeat (TIMEOUT) @(posedge clk_sys);
        $display("timeout: capture did not finish within %0d cycles", TIMEOUT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        capture_pkg::word_t d;
        int aw_before;
        rst_sys_n  = 1'b0;
        video_data = '0;
        video_de   = 1'b0;
        video_hs   = 1'b0;
        video_vs   = 1'b0;
        csr_addr   = '0;
        csr_read   = 1'b0;
        csr_write  = 1'b0;
        csr_wdata  = '0;
        repeat (4) @(posedge clk_sys);
        rst_sys_n <= 1'b1;

        read_reg(capture_pkg::REG_CTRL, d);
        check_value(d, 0, "ctrl after reset");
        read_reg(capture_pkg::REG_START_ADDR, d);
        check_value(d, 0, "start_addr after reset");
        base = BASE0;
        write_reg(capture_pkg::REG_START_ADDR, BASE0);
        write_reg(capture_pkg::REG_CTRL, 32'h1);
        read_reg(capture_pkg::REG_START_ADDR, d);
        check_value(d, BASE0, "start_addr readback");
        read_reg(capture_pkg::REG_CTRL, d);
        check_value(d, 1, "ctrl readback");

        // second frame lands on the same buffer as the first
        run_frame(NUM_LINES);
        run_frame(NUM_LINES);

        // frame larger than the FIFO while DMA is disabled
        write_reg(capture_pkg::REG_CTRL, 32'h0);
        aw_before = aw_count;
        frame_q.delete();
        send_lines(BIG_LINES);
        repeat (20) @(posedge clk_sys);
        vsync_pulse();
        check_value(aw_count, aw_before, "AW count while disabled");
        check_stats(BIG_LINES, 1'b1);
        base = BASE1;
        write_reg(capture_pkg::REG_START_ADDR, BASE1);
        write_reg(capture_pkg::REG_CTRL, 32'h1);
        wait_drain();
        check_memory();

        $display("errors: %0d, words checked: %0d, bursts: %0d",
                 errors, words_checked, aw_count);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
src/capture_pkg.sv
src/fifo_rd_if.sv
src/video_stats_if.sv
src/pixel_repacker.sv
src/pixel_fifo.sv
src/video_stats.sv
src/csr_regs.sv
src/burst_ctrl.sv
src/capture_top.sv
verification/tb_capture.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_capture \
		-f src.f -Mdir obj_dir -o sim_capture

run: compile
	./obj_dir/sim_capture | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
